// File: source/periph_pkg.sv
package periph_pkg;

  //////////////////////////////
  // region map

  // one value per decoded region on the internal bus
  typedef enum logic [2:0] {
    REGION_RAM,
    REGION_LED,
    REGION_SWITCH,
    REGION_SEG,
    REGION_NONE     // unmapped
  } region_e;

  //////////////////////////////
  // axi response codes

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;  // write to a read-only register
  localparam logic [1:0] RESP_DECERR = 2'b11;  // nothing lives at the address

  //////////////////////////////
  // address map

  // ram sits at 0 and grows upward, I/O window starts here
  localparam logic [31:0] IO_BASE = 32'h0000_1000;

  // byte offsets inside the I/O window
  localparam logic [11:0] LED_OFFSET    = 12'h000;
  localparam logic [11:0] SWITCH_OFFSET = 12'h004;  // read only
  localparam logic [11:0] SEG_OFFSET    = 12'h008;

endpackage

// File: source/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder
  import periph_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic [31:0] addr,
  output region_e     region
);

  // first byte past the end of the ram
  localparam logic [31:0] RAM_LIMIT = 32'(RAM_WORDS * 4);

  logic io_window;

  // page compare, the window is one 4 KiB page
  assign io_window = (addr[31:12] == IO_BASE[31:12]);

  always_comb begin
    region = REGION_NONE;
    if (addr < RAM_LIMIT) begin
      region = REGION_RAM;
    end else if (io_window) begin
      // only the exact register offsets are mapped
      case (addr[11:0])
        LED_OFFSET:    region = REGION_LED;
        SWITCH_OFFSET: region = REGION_SWITCH;
        SEG_OFFSET:    region = REGION_SEG;
        default:       region = REGION_NONE;
      endcase
    end
  end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic        clk_100mhz,
  input  logic        sel,
  input  logic [3:0]  wstrb,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  // word index width, at least one bit
  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [31:0]      mem [RAM_WORDS];
  logic [IDX_W-1:0] word_idx;

  assign word_idx = addr[IDX_W+1:2];  // drop the byte offset

  //////////////////////////////
  // byte lane writes, registered read

  always_ff @(posedge clk_100mhz) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (sel && wstrb[lane]) begin
        mem[word_idx][8*lane +: 8] <= wdata[8*lane +: 8];
      end
    end
    rdata <= mem[word_idx];  // old word on a write cycle
  end

endmodule

// File: source/io_regs.sv
`timescale 1ns/1ps

module io_regs
  import periph_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        arst_n,
  input  logic        sel,
  input  logic [3:0]  wstrb,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [15:0] switch,
  output logic [31:0] rdata,
  output logic [15:0] led,
  output logic [31:0] seg_value
);

  logic        led_wr;
  logic        seg_wr;
  logic [15:0] switch_meta;  // first flop, may go metastable
  logic [15:0] switch_sync;

  // register select from address bits 3:2
  assign led_wr = sel && (addr[3:2] == LED_OFFSET[3:2]);
  assign seg_wr = sel && (addr[3:2] == SEG_OFFSET[3:2]);

  //////////////////////////////
  // writable registers and switch sync

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      led         <= '0;
      seg_value   <= '0;
      switch_meta <= '0;
      switch_sync <= '0;
    end else begin
      for (int lane = 0; lane < 2; lane++) begin
        if (led_wr && wstrb[lane]) begin
          led[8*lane +: 8] <= wdata[8*lane +: 8];
        end
      end
      for (int lane = 0; lane < 4; lane++) begin
        if (seg_wr && wstrb[lane]) begin
          seg_value[8*lane +: 8] <= wdata[8*lane +: 8];
        end
      end
      switch_meta <= switch;
      switch_sync <= switch_meta;
    end
  end

  // readback word, lines up with the ram read
  always_ff @(posedge clk_100mhz) begin
    case (addr[3:2])
      LED_OFFSET[3:2]:    rdata <= {16'h0000, led};
      SWITCH_OFFSET[3:2]: rdata <= {16'h0000, switch_sync};
      SEG_OFFSET[3:2]:    rdata <= seg_value;
      default:            rdata <= '0;
    endcase
  end

endmodule

// File: source/read_return.sv
`timescale 1ns/1ps

module read_return
  import periph_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        arst_n,
  input  logic        bus_rd,
  input  region_e     region,
  input  logic [31:0] ram_rdata,
  input  logic [31:0] io_rdata,
  output logic [31:0] rdata
);

  region_e region_q;  // region of the last read

  // capture on the read strobe, data arrives a cycle later
  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      region_q <= REGION_NONE;
    end else if (bus_rd) begin
      region_q <= region;
    end
  end

  //////////////////////////////
  // return mux

  always_comb begin
    case (region_q)
      REGION_RAM: begin
        rdata = ram_rdata;
      end
      REGION_LED, REGION_SWITCH, REGION_SEG: begin
        rdata = io_rdata;
      end
      default: begin
        rdata = '0;  // unmapped reads return zero
      end
    endcase
  end

endmodule

// File: source/axil_slave_port.sv
`timescale 1ns/1ps

module axil_slave_port
  import periph_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        arst_n,
  // write address
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  // write data
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  // write response
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  // read address
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  // read data
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  // internal bus
  input  region_e     region,
  input  logic [31:0] bus_rdata,
  output logic [31:0] bus_addr,
  output logic [31:0] bus_wdata,
  output logic [3:0]  bus_wstrb,
  output logic        bus_rd
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_WR_ISSUE = 3'd1;
  localparam logic [2:0] ST_WR_RESP  = 3'd2;
  localparam logic [2:0] ST_RD_ISSUE = 3'd3;
  localparam logic [2:0] ST_RD_RESP  = 3'd4;

  logic [2:0]  state;
  logic        aw_held;
  logic        w_held;
  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        aw_have;   // address half here now or held
  logic        w_have;
  logic        wr_ok;     // region takes a write strobe
  logic        r_first;   // first cycle of rvalid
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  logic [31:0] rdata_q;
  logic [1:0]  resp_q;

  //////////////////////////////
  // handshakes

  assign awready = (state == ST_IDLE) && !aw_held;
  assign wready  = (state == ST_IDLE) && !w_held;
  // reads wait while any write half is pending or arriving
  assign arready = (state == ST_IDLE) && !aw_held && !w_held && !awvalid && !wvalid;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign ar_fire = arvalid && arready;
  assign aw_have = aw_held || aw_fire;
  assign w_have  = w_held || w_fire;

  assign wr_ok = (region == REGION_RAM) || (region == REGION_LED) || (region == REGION_SEG);

  //////////////////////////////
  // sequencer

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      r_first <= 1'b0;
    end else begin
      r_first <= (state == ST_RD_ISSUE);
      case (state)
        ST_IDLE: begin
          if (aw_have && w_have) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            state   <= ST_WR_ISSUE;
          end else begin
            aw_held <= aw_have;
            w_held  <= w_have;
            if (ar_fire) begin
              state <= ST_RD_ISSUE;
            end
          end
        end
        ST_WR_ISSUE: state <= ST_WR_RESP;
        ST_WR_RESP:  if (bready) state <= ST_IDLE;
        ST_RD_ISSUE: state <= ST_RD_RESP;
        ST_RD_RESP:  if (rready) state <= ST_IDLE;
        default:     state <= ST_IDLE;
      endcase
    end
  end

  // captured request and response payload
  always_ff @(posedge clk_100mhz) begin
    if (aw_fire) begin
      addr_q <= awaddr;
    end else if (ar_fire) begin
      addr_q <= araddr;
    end
    if (w_fire) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (state == ST_WR_ISSUE) begin
      if (region == REGION_NONE) begin
        resp_q <= RESP_DECERR;
      end else if (region == REGION_SWITCH) begin
        resp_q <= RESP_SLVERR;
      end else begin
        resp_q <= RESP_OKAY;
      end
    end
    if (state == ST_RD_ISSUE) begin
      resp_q <= (region == REGION_NONE) ? RESP_DECERR : RESP_OKAY;
    end
    if (r_first) begin
      rdata_q <= bus_rdata;  // freeze while the master stalls
    end
  end

  //////////////////////////////
  // outputs

  assign bus_addr  = addr_q;
  assign bus_wdata = wdata_q;
  assign bus_wstrb = (state == ST_WR_ISSUE && wr_ok) ? wstrb_q : 4'b0000;
  assign bus_rd    = (state == ST_RD_ISSUE);

  assign bvalid = (state == ST_WR_RESP);
  assign bresp  = resp_q;
  assign rvalid = (state == ST_RD_RESP);
  assign rresp  = resp_q;
  assign rdata  = r_first ? bus_rdata : rdata_q;

endmodule

// File: source/periph_bus_top.sv
`timescale 1ns/1ps

module periph_bus_top
  import periph_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic        clk_100mhz,
  input  logic        arst_n,
  // axi4-lite slave
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  // board I/O
  input  logic [15:0] switch,
  output logic [15:0] led,
  output logic [31:0] seg_value
);

  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [3:0]  bus_wstrb;
  logic        bus_rd;
  logic [31:0] bus_rdata;
  logic [31:0] ram_rdata;
  logic [31:0] io_rdata;
  region_e     region;
  logic        ram_sel;
  logic        io_sel;

  assign ram_sel = (region == REGION_RAM);
  assign io_sel  = region inside {REGION_LED, REGION_SWITCH, REGION_SEG};

  axil_slave_port u_axil_slave_port (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .region(region), .bus_rdata(bus_rdata), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb), .bus_rd(bus_rd)
  );

  addr_decoder #(.RAM_WORDS(RAM_WORDS)) u_addr_decoder (.addr(bus_addr), .region(region));

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
    .clk_100mhz(clk_100mhz), .sel(ram_sel), .wstrb(bus_wstrb),
    .addr(bus_addr), .wdata(bus_wdata), .rdata(ram_rdata)
  );

  io_regs u_io_regs (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .sel(io_sel), .wstrb(bus_wstrb),
    .addr(bus_addr), .wdata(bus_wdata), .switch(switch), .rdata(io_rdata),
    .led(led), .seg_value(seg_value)
  );

  read_return u_read_return (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .bus_rd(bus_rd), .region(region),
    .ram_rdata(ram_rdata), .io_rdata(io_rdata), .rdata(bus_rdata)
  );

endmodule

// File: sim/tb_periph_bus.sv
`timescale 1ns/1ps

module tb_periph_bus;

  localparam int RAM_WORDS = 256;
  localparam int IDX_W     = $clog2(RAM_WORDS);
  localparam int N_RAM     = 64;   // random ram locations
  localparam int N_MIXED   = 100;
  // preload, ram write and readback, mixed run, about 40 directed accesses
  localparam int N_TRANS     = RAM_WORDS + 2 * N_RAM + N_MIXED + 40;
  localparam int CYCLE_LIMIT = N_TRANS * 20 + 200;

  localparam logic [1:0]  OKAY        = 2'b00;
  localparam logic [1:0]  SLVERR      = 2'b10;
  localparam logic [1:0]  DECERR      = 2'b11;
  localparam logic [31:0] IO_BASE     = 32'h0000_1000;
  localparam logic [31:0] LED_ADDR    = IO_BASE + 32'h0;
  localparam logic [31:0] SWITCH_ADDR = IO_BASE + 32'h4;
  localparam logic [31:0] SEG_ADDR    = IO_BASE + 32'h8;
  localparam logic [31:0] RAM_BYTES   = 32'(RAM_WORDS * 4);

  localparam int KIND_RAM    = 0;
  localparam int KIND_LED    = 1;
  localparam int KIND_SWITCH = 2;
  localparam int KIND_SEG    = 3;
  localparam int KIND_NONE   = 4;

  logic clk_100mhz, arst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata, seg_value;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic [15:0] switch, led;

  logic [31:0] shadow_ram [RAM_WORDS];  // reference model state
  logic [15:0] shadow_led = '0;
  logic [31:0] shadow_seg = '0;
  logic [31:0] rng_state;

  bit          exp_read_q [$];  // one entry per request in issue order
  logic [1:0]  exp_resp_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_head    = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  bit          reset_check = 0;
  bit          b_hold = 0;
  bit          r_hold = 0;
  logic [1:0]  b_resp_held, r_resp_held;
  logic [31:0] r_data_held;

  periph_bus_top #(.RAM_WORDS(RAM_WORDS)) u_periph_bus_top (.*);

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  //////////////////////////////
  // reference model

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int address_kind(input logic [31:0] addr);
    if (addr < RAM_BYTES) return KIND_RAM;
    if (addr == LED_ADDR) return KIND_LED;
    if (addr == SWITCH_ADDR) return KIND_SWITCH;
    if (addr == SEG_ADDR) return KIND_SEG;
    return KIND_NONE;  // includes unaligned offsets in the io page
  endfunction

  function automatic logic [1:0] expect_resp(input logic [31:0] addr, input bit is_write,
                                             output logic [31:0] word);
    word = '0;
    case (address_kind(addr))
      KIND_RAM:    word = shadow_ram[addr[IDX_W+1:2]];
      KIND_LED:    word = {16'h0000, shadow_led};
      KIND_SWITCH: begin
        word = {16'h0000, switch};
        if (is_write) return SLVERR;  // read only
      end
      KIND_SEG:    word = shadow_seg;
      default:     return DECERR;
    endcase
    return OKAY;
  endfunction

  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        case (address_kind(addr))
          KIND_RAM: shadow_ram[addr[IDX_W+1:2]][8*lane +: 8] = data[8*lane +: 8];
          KIND_LED: if (lane < 2) shadow_led[8*lane +: 8] = data[8*lane +: 8];
          KIND_SEG: shadow_seg[8*lane +: 8] = data[8*lane +: 8];
          default: ;
        endcase
      end
    end
  endtask

  //////////////////////////////
  // axi driver

  // holds off bready or rready for 0 to 3 cycles of valid
  task automatic take_response(input bit is_read);
    int   stall;
    bit   fired;
    logic valid_now;
    logic ready_now;
    stall = next_random() % 4;
    fired = 1'b0;
    bready = !is_read && (stall == 0);
    rready = is_read && (stall == 0);
    while (!fired) begin
      @(posedge clk_100mhz);
      valid_now = is_read ? rvalid : bvalid;
      ready_now = is_read ? rready : bready;
      fired = valid_now && ready_now;
      if (valid_now && !ready_now && stall > 0) stall--;
      @(negedge clk_100mhz);
      bready = !is_read && !fired && (stall == 0);
      rready = is_read && !fired && (stall == 0);
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] word;
    logic [1:0]  resp;
    bit          aw_done;
    bit          w_done;
    resp = expect_resp(addr, 1'b1, word);
    exp_read_q.push_back(1'b0);
    exp_resp_q.push_back(resp);
    exp_data_q.push_back(word);
    apply_write(addr, data, strb);
    @(negedge clk_100mhz);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    aw_done = 1'b0;
    w_done  = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk_100mhz);
      aw_done = aw_done || (awvalid && awready);
      w_done  = w_done || (wvalid && wready);
      @(negedge clk_100mhz);
      awvalid = !aw_done;
      wvalid  = !w_done;
    end
    take_response(1'b0);
  endtask

  task automatic axi_read(input logic [31:0] addr);
    logic [31:0] word;
    logic [1:0]  resp;
    bit          ar_done;
    resp = expect_resp(addr, 1'b0, word);
    exp_read_q.push_back(1'b1);
    exp_resp_q.push_back(resp);
    exp_data_q.push_back(word);
    @(negedge clk_100mhz);
    arvalid = 1'b1;
    araddr  = addr;
    ar_done = 1'b0;
    while (!ar_done) begin
      @(posedge clk_100mhz);
      ar_done = arvalid && arready;
      @(negedge clk_100mhz);
      arvalid = !ar_done;
    end
    take_response(1'b1);
  endtask

  // long rready stall on a switch read while the switch input moves
  task automatic stalled_switch_read(input logic [15:0] next_switch);
    logic [31:0] word;
    logic [1:0]  resp;
    bit          ar_done;
    resp = expect_resp(SWITCH_ADDR, 1'b0, word);
    exp_read_q.push_back(1'b1);
    exp_resp_q.push_back(resp);
    exp_data_q.push_back(word);
    @(negedge clk_100mhz);
    arvalid = 1'b1;
    araddr  = SWITCH_ADDR;
    ar_done = 1'b0;
    while (!ar_done) begin
      @(posedge clk_100mhz);
      ar_done = arvalid && arready;
      @(negedge clk_100mhz);
      arvalid = !ar_done;
    end
    rready = 1'b0;
    while (!rvalid) @(negedge clk_100mhz);
    switch = next_switch;  // returned word stays the old one
    repeat (5) @(negedge clk_100mhz);
    rready = 1'b1;
    @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    rready = 1'b0;
  endtask

  //////////////////////////////
  // compare and timeout

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("at %0t ns: %s", $time, what);
  endtask

  always @(posedge clk_100mhz) begin
    if (arst_n) begin
      if (reset_check) begin
        check_count++;
        if (led !== 16'h0000) report_mismatch("led", 32'h0, 32'(led));
        if (seg_value !== 32'h0) report_mismatch("seg_value", 32'h0, seg_value);
      end
      // stalled beat must keep valid and payload
      if (b_hold && !bvalid) report_failure("bvalid dropped before bready");
      if (b_hold && bresp !== b_resp_held) report_mismatch("bresp", 32'(b_resp_held), 32'(bresp));
      if (r_hold && !rvalid) report_failure("rvalid dropped before rready");
      if (r_hold && rresp !== r_resp_held) report_mismatch("rresp", 32'(r_resp_held), 32'(rresp));
      if (r_hold && rdata !== r_data_held) report_mismatch("rdata", r_data_held, rdata);
      // nothing new is accepted while a response waits
      if ((bvalid || rvalid) && (awready || wready || arready)) begin
        report_failure("a ready was high while a response was pending");
      end
      b_hold      = bvalid && !bready;
      b_resp_held = bresp;
      r_hold      = rvalid && !rready;
      r_resp_held = rresp;
      r_data_held = rdata;
      if ((bvalid && bready) || (rvalid && rready)) begin
        if (exp_head >= exp_read_q.size()) begin
          report_failure("response beat with no request outstanding");
        end else if (exp_read_q[exp_head] != (rvalid && rready)) begin
          report_failure("response came back on the wrong channel");
          exp_head++;
        end else begin
          check_count++;
          if (rvalid) begin
            if (rresp !== exp_resp_q[exp_head]) begin
              report_mismatch("rresp", 32'(exp_resp_q[exp_head]), 32'(rresp));
            end
            if (rdata !== exp_data_q[exp_head]) report_mismatch("rdata", exp_data_q[exp_head], rdata);
          end else if (bresp !== exp_resp_q[exp_head]) begin
            report_mismatch("bresp", 32'(exp_resp_q[exp_head]), 32'(bresp));
          end
          if (led !== shadow_led) report_mismatch("led", 32'(shadow_led), 32'(led));
          if (seg_value !== shadow_seg) report_mismatch("seg_value", shadow_seg, seg_value);
          exp_head++;
        end
      end else if ((bvalid || rvalid) && exp_head >= exp_read_q.size()) begin
        report_failure("bvalid or rvalid raised with no request");
      end
    end
  end

  always @(posedge clk_100mhz) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the run was still busy after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence

  initial begin
    logic [31:0] addr;
    logic [31:0] pick;
    logic [31:0] ram_addr [N_RAM];
    int          missing;
    rng_state = 32'd4428;
    arst_n  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    switch  = 16'h0000;
    repeat (10) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    arst_n = 1'b1;

    repeat (20) @(negedge clk_100mhz);  // idle time where nothing may answer
    reset_check = 1'b1;
    @(negedge clk_100mhz);
    reset_check = 1'b0;

    // block ram powers up undefined so every word is filled first
    for (int i = 0; i < RAM_WORDS; i++) begin
      addr = 32'(i * 4);
      axi_write(addr, (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F, 4'hF);
    end

    for (int i = 0; i < N_RAM; i++) begin
      ram_addr[i] = (next_random() % RAM_WORDS) * 4;
      axi_write(ram_addr[i], next_random(), 4'(next_random()));
    end
    for (int i = 0; i < N_RAM; i++) begin
      axi_read(ram_addr[i]);
    end

    // led keeps only the low two lanes
    axi_write(LED_ADDR, 32'h1234_5678, 4'b0011);
    axi_read(LED_ADDR);
    axi_write(LED_ADDR, 32'hFFFF_ABCD, 4'b0010);
    axi_read(LED_ADDR);
    axi_write(LED_ADDR, 32'hCAFE_0000, 4'b1100);
    axi_read(LED_ADDR);
    axi_write(SEG_ADDR, 32'hDEAD_BEEF, 4'b1111);
    axi_read(SEG_ADDR);
    axi_write(SEG_ADDR, 32'h0102_0304, 4'b0101);
    axi_read(SEG_ADDR);
    axi_write(SEG_ADDR, 32'h7700_0000, 4'b1000);
    axi_read(SEG_ADDR);
    for (int i = 0; i < 2; i++) begin
      switch = 16'(next_random());
      repeat (5) @(negedge clk_100mhz);  // through the synchronizer
      axi_read(SWITCH_ADDR);
    end
    stalled_switch_read(~switch);

    axi_write(SWITCH_ADDR, 32'hFFFF_FFFF, 4'hF);
    axi_read(LED_ADDR);
    axi_read(SEG_ADDR);
    axi_read(SWITCH_ADDR);
    axi_read(32'h0000_0004);  // same low index bits as the switch register
    axi_write(IO_BASE + 32'h10, 32'h1111_2222, 4'hF);
    axi_read(IO_BASE + 32'h10);
    axi_write(RAM_BYTES, 32'h3333_4444, 4'hF);
    axi_read(RAM_BYTES);
    axi_read(32'h0000_0000);  // must not have wrapped into word 0
    axi_read(IO_BASE + 32'h2);
    axi_write(32'h8000_0000, 32'h5555_6666, 4'hF);
    axi_read(32'h8000_0000);

    for (int i = 0; i < N_MIXED; i++) begin
      pick = next_random();
      case (pick[2:0])
        3'd0:    addr = LED_ADDR;
        3'd1:    addr = SEG_ADDR;
        3'd2:    addr = SWITCH_ADDR;
        3'd3:    addr = IO_BASE + 32'h0C;  // hole after seg
        default: addr = (next_random() % RAM_WORDS) * 4;
      endcase
      if (pick[3]) begin
        axi_write(addr, next_random(), 4'(next_random()));
      end else begin
        axi_read(addr);
      end
    end

    repeat (4) @(negedge clk_100mhz);
    missing = exp_read_q.size() - exp_head;
    if (missing != 0) $display("%0d requests never got a response", missing);
    $display("checks %0d, errors %0d, missing responses %0d", check_count, error_count, missing);
    if (error_count == 0 && missing == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
source/periph_pkg.sv
source/addr_decoder.sv
source/data_ram.sv
source/io_regs.sv
source/read_return.sv
source/axil_slave_port.sv
source/periph_bus_top.sv
sim/tb_periph_bus.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_periph_bus
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

# pass only when the pass line shows up in the simulation output
run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
